// File: hw/if_pkg.sv
// shared types and select codes for the instruction fetch subsystem, imported by every block
package if_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // data types
  ////////////////////////////////////////////////////////////////////////////

  typedef logic [31:0] addr_t;        // byte address
  typedef logic [31:0] instr_t;       // one instruction word
  typedef logic [3:0]  pc_mux_t;      // next pc source select
  typedef logic [1:0]  exc_pc_mux_t;  // trap kind select

  ////////////////////////////////////////////////////////////////////////////
  // next pc sources
  ////////////////////////////////////////////////////////////////////////////

  localparam pc_mux_t PC_BOOT      = 4'b0000;  // reset vector
  localparam pc_mux_t PC_FENCEI    = 4'b0001;  // refetch after fence.i
  localparam pc_mux_t PC_JUMP      = 4'b0010;  // jump resolved in ID
  localparam pc_mux_t PC_BRANCH    = 4'b0011;  // branch resolved in EX
  localparam pc_mux_t PC_EXCEPTION = 4'b0100;  // trap entry
  localparam pc_mux_t PC_MRET      = 4'b0101;  // return from machine trap
  localparam pc_mux_t PC_DRET      = 4'b0111;  // return from debug mode

  // trap kinds
  localparam exc_pc_mux_t EXC_PC_EXCEPTION = 2'b00;  // synchronous exception
  localparam exc_pc_mux_t EXC_PC_IRQ       = 2'b01;  // vectored interrupt
  localparam exc_pc_mux_t EXC_PC_DBD       = 2'b10;  // debug halt entry

  ////////////////////////////////////////////////////////////////////////////
  // sizing
  ////////////////////////////////////////////////////////////////////////////

  localparam int    IF_FIFO_DEPTH   = 4;      // default prefetch depth, power of two
  localparam int    MAX_OUTSTANDING = 2;      // bus requests in flight at most
  localparam addr_t WORD_BYTES      = 32'd4;  // one word step

endpackage

// File: hw/fetch_stream_if.sv
// fetch stream between prefetch buffer and IF pipe stage, carries redirects one way and words back
`timescale 1ns/10ps

interface fetch_stream_if import if_pkg::*; ();

  // redirect, owned by the pipe stage
  logic   branch;       // one cycle pulse, flushes the buffer
  addr_t  branch_addr;  // registered target, valid from the cycle after the pulse

  // word stream, owned by the buffer
  logic   fetch_valid;  // head of fifo holds a word
  instr_t fetch_rdata;  // head word
  addr_t  fetch_addr;   // pc of head word

  // pop strobe from the pipe stage
  logic   fetch_ready;  // word taken when valid and ready are both high

  // buffer side
  modport buf_mp (
    input  branch,
    input  branch_addr,
    input  fetch_ready,
    output fetch_valid,
    output fetch_rdata,
    output fetch_addr
  );

  // pipe stage side
  modport pipe_mp (
    output branch,
    output branch_addr,
    output fetch_ready,
    input  fetch_valid,
    input  fetch_rdata,
    input  fetch_addr
  );

endinterface

// File: hw/pc_target_sel.sv
// next fetch address selection with trap vector formation, purely combinational
`timescale 1ns/10ps

module pc_target_sel import if_pkg::*; (
  input  addr_t        boot_addr_i,         // reset vector, used as is
  input  addr_t        jump_target_id_i,    // jump from ID
  input  addr_t        jump_target_ex_i,    // branch from EX
  input  addr_t        mepc_i,              // machine trap return address
  input  addr_t        depc_i,              // debug return address
  input  addr_t        pc_i,                // pc of the fence.i
  input  logic [23:0]  m_trap_base_addr_i,  // mtvec upper bits
  input  logic [29:0]  dm_halt_addr_i,      // debug module halt word address
  input  logic [5:0]   m_exc_vec_pc_mux_i,  // interrupt vector number
  input  pc_mux_t      pc_mux_i,
  input  exc_pc_mux_t  exc_pc_mux_i,
  output addr_t        branch_target_o
);

  addr_t exc_pc;          // trap handler address
  logic  inputs_aligned;  // every plain address input on a word boundary

  ////////////////////////////////////////////////////////////////////////////
  // trap vector
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    unique case (exc_pc_mux_i)
      EXC_PC_EXCEPTION: exc_pc = {m_trap_base_addr_i, 8'h00};  // all exceptions share the base
      EXC_PC_IRQ:       exc_pc = {m_trap_base_addr_i, m_exc_vec_pc_mux_i, 2'b00};  // base + 4*id
      EXC_PC_DBD:       exc_pc = {dm_halt_addr_i, 2'b00};
      default:          exc_pc = {m_trap_base_addr_i, 8'h00};
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // next pc mux
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    unique case (pc_mux_i)
      PC_BOOT:      branch_target_o = boot_addr_i;
      PC_JUMP:      branch_target_o = jump_target_id_i;
      PC_BRANCH:    branch_target_o = jump_target_ex_i;
      PC_EXCEPTION: branch_target_o = exc_pc;
      PC_MRET:      branch_target_o = mepc_i;
      PC_DRET:      branch_target_o = depc_i;
      PC_FENCEI:    branch_target_o = pc_i + WORD_BYTES;  // refetch the next word
      default:      branch_target_o = boot_addr_i;        // unused codes fall back to boot
    endcase
  end

  // trap forms are aligned by construction, so only these matter
  assign inputs_aligned = (boot_addr_i[1:0] == 2'b00) &&
                          (jump_target_id_i[1:0] == 2'b00) &&
                          (jump_target_ex_i[1:0] == 2'b00) &&
                          (mepc_i[1:0] == 2'b00) &&
                          (depc_i[1:0] == 2'b00) &&
                          (pc_i[1:0] == 2'b00);

  // no clock here, so checked once the inputs settle
  always_comb begin
    if (inputs_aligned) begin
      a_target_aligned : assert final (branch_target_o[1:0] == 2'b00)
        else $error("next fetch address not word aligned, pc_mux %0h", pc_mux_i);
    end
  end

endmodule

// File: hw/prefetch_buffer.sv
// bus request engine and prefetch fifo, pairs each returned word with its fetch address
`timescale 1ns/10ps

module prefetch_buffer import if_pkg::*; #(
  parameter int FIFO_DEPTH = IF_FIFO_DEPTH  // words, power of two
) (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           req_i,           // fetching enabled
  fetch_stream_if.buf_mp fs,
  output logic           instr_req_o,
  output addr_t          instr_addr_o,
  input  logic           instr_gnt_i,
  input  logic           instr_rvalid_i,
  input  instr_t         instr_rdata_i,
  output logic           busy_o
);

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  // request side
  addr_t            addr_q;       // held or next sequential request address
  logic             hold_q;       // last request not granted, keep it up
  logic             redirect_q;   // next new request starts at branch_addr
  logic [1:0]       out_cnt_q;    // granted, no response yet
  logic [1:0]       out_cnt_d;
  logic [1:0]       disc_q;       // outstanding responses to throw away
  logic [1:0]       live_out;     // outstanding responses that will be kept
  logic             issue_ok;
  logic             granted;
  logic             stale_gnt;    // grant belongs to the old stream
  logic             new_stream;   // first request after a redirect goes out

  // response side
  logic             resp_drop;
  logic             resp_keep;
  addr_t            resp_addr_q;  // pc of the next kept response
  logic             push;
  logic             pop;

  // fifo storage
  instr_t           fifo_data [FIFO_DEPTH];
  addr_t            fifo_addr [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] fifo_cnt_q;
  logic [CNT_W:0]   level;        // buffered plus live in flight

  ////////////////////////////////////////////////////////////////////////////
  // request generation
  ////////////////////////////////////////////////////////////////////////////

  assign live_out = out_cnt_q - disc_q;
  assign level    = (CNT_W+1)'(fifo_cnt_q) + (CNT_W+1)'(live_out);

  // stop issuing once every fifo slot is spoken for
  assign issue_ok = req_i & ~fs.branch &
                    (out_cnt_q < MAX_OUTSTANDING) &
                    (level < FIFO_DEPTH);

  assign instr_req_o  = hold_q | issue_ok;  // an ungranted request never drops
  assign instr_addr_o = (redirect_q & ~hold_q) ? fs.branch_addr : addr_q;

  assign granted    = instr_req_o & instr_gnt_i;
  assign new_stream = instr_req_o & redirect_q & ~hold_q;
  // a held request overtaken by a branch still completes, its data is junk
  assign stale_gnt  = granted & (fs.branch | (hold_q & redirect_q));

  ////////////////////////////////////////////////////////////////////////////
  // response handling
  ////////////////////////////////////////////////////////////////////////////

  assign resp_drop = instr_rvalid_i & (disc_q != 2'd0);
  assign resp_keep = instr_rvalid_i & (disc_q == 2'd0) & ~fs.branch;
  assign push      = resp_keep;
  assign pop       = fs.fetch_valid & fs.fetch_ready & ~fs.branch;

  assign out_cnt_d = out_cnt_q + {1'b0, granted} - {1'b0, instr_rvalid_i};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      hold_q     <= 1'b0;
      redirect_q <= 1'b0;
      out_cnt_q  <= 2'd0;
      disc_q     <= 2'd0;
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      fifo_cnt_q <= '0;
    end else begin
      hold_q    <= instr_req_o & ~instr_gnt_i;
      out_cnt_q <= out_cnt_d;
      if (fs.branch) begin
        redirect_q <= 1'b1;
        disc_q     <= out_cnt_d;  // everything still in flight is stale
        wr_ptr_q   <= '0;         // flush
        rd_ptr_q   <= '0;
        fifo_cnt_q <= '0;
      end else begin
        if (new_stream) begin
          redirect_q <= 1'b0;
        end
        disc_q     <= disc_q - {1'b0, resp_drop} + {1'b0, stale_gnt};
        if (push) begin
          wr_ptr_q <= wr_ptr_q + 1'b1;  // wraps, depth is a power of two
        end
        if (pop) begin
          rd_ptr_q <= rd_ptr_q + 1'b1;
        end
        fifo_cnt_q <= fifo_cnt_q + CNT_W'(push) - CNT_W'(pop);
      end
    end
  end

  // addresses and fifo payload
  always_ff @(posedge clk) begin
    if (instr_req_o) begin
      addr_q <= instr_gnt_i ? (instr_addr_o + WORD_BYTES) : instr_addr_o;
    end
    if (new_stream) begin
      resp_addr_q <= fs.branch_addr;           // first kept word is the target
    end else if (push) begin
      resp_addr_q <= resp_addr_q + WORD_BYTES;
    end
    if (push) begin
      fifo_data[wr_ptr_q] <= instr_rdata_i;
      fifo_addr[wr_ptr_q] <= resp_addr_q;
    end
  end

  assign fs.fetch_valid = (fifo_cnt_q != '0);
  assign fs.fetch_rdata = fifo_data[rd_ptr_q];
  assign fs.fetch_addr  = fifo_addr[rd_ptr_q];

  assign busy_o = (out_cnt_q != 2'd0) | fs.fetch_valid;

  ////////////////////////////////////////////////////////////////////////////
  // bus protocol checks
  ////////////////////////////////////////////////////////////////////////////

  a_rvalid_expected : assert property (@(posedge clk) disable iff (!rst_n)
    instr_rvalid_i |-> (out_cnt_q != 2'd0))
    else $error("rvalid with no request outstanding");

  a_addr_stable : assert property (@(posedge clk) disable iff (!rst_n)
    (instr_req_o && !instr_gnt_i) |=> (instr_req_o && $stable(instr_addr_o)))
    else $error("request dropped or address changed before grant");

endmodule

// File: hw/if_pipe.sv
// IF control FSM, redirect issue and the IF/ID register that feeds decode
`timescale 1ns/10ps

module if_pipe import if_pkg::*; (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            req_i,                // core wants instructions
  input  logic            pc_set_i,             // redirect to branch_target_i
  input  addr_t           branch_target_i,      // from the target selector
  fetch_stream_if.pipe_mp fs,
  input  logic            halt_if_i,            // hold the stage
  input  logic            id_ready_i,           // decode can take a word
  input  logic            clear_instr_valid_i,  // kill the word in IF/ID
  output logic            instr_valid_id_o,
  output instr_t          instr_rdata_id_o,
  output addr_t           pc_id_o,
  output logic            perf_imiss_o          // no word for decode this cycle
);

  typedef enum logic {
    IDLE,  // nothing requested yet
    WAIT   // streaming from the buffer
  } fetch_state_e;

  fetch_state_e state_q, state_d;

  logic  branch;         // redirect pulse
  logic  valid;          // word available to ID
  logic  transfer;       // word moves into IF/ID
  addr_t branch_addr_q;  // target captured at the redirect

  ////////////////////////////////////////////////////////////////////////////
  // control FSM
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d = state_q;
    branch  = 1'b0;
    valid   = 1'b0;

    unique case (state_q)
      IDLE: begin
        if (req_i) begin
          branch  = 1'b1;  // first fetch, boot target when selected
          state_d = WAIT;
        end
      end
      WAIT: begin
        valid = fs.fetch_valid;
      end
      default: begin
        state_d = IDLE;
      end
    endcase

    // redirect wins over everything, the head word is stale
    if (pc_set_i) begin
      valid   = 1'b0;
      branch  = 1'b1;
      state_d = WAIT;
    end
  end

  assign transfer = valid & id_ready_i & ~halt_if_i;

  assign fs.fetch_ready = transfer;
  assign fs.branch      = branch;
  assign fs.branch_addr = branch_addr_q;

  // buffer picks this up one cycle after the pulse
  always_ff @(posedge clk) begin
    if (branch) begin
      branch_addr_q <= branch_target_i;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // IF/ID register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      instr_valid_id_o <= 1'b0;
    end else if (transfer) begin
      instr_valid_id_o <= 1'b1;
    end else if (clear_instr_valid_i) begin
      instr_valid_id_o <= 1'b0;  // new load beats the clear
    end
  end

  always_ff @(posedge clk) begin
    if (transfer) begin
      instr_rdata_id_o <= fs.fetch_rdata;
      pc_id_o          <= fs.fetch_addr;
    end
  end

  assign perf_imiss_o = ~fs.fetch_valid | branch;

  // decode stalled, so word and pc stay put
  a_ifid_hold : assert property (@(posedge clk) disable iff (!rst_n)
    (!id_ready_i && instr_valid_id_o) |=>
      ($stable(instr_rdata_id_o) && $stable(pc_id_o)))
    else $error("IF/ID register changed while decode stalled");

endmodule

// File: hw/fetch_unit.sv
// instruction fetch top level, wires target selector, prefetch buffer and IF stage to plain ports
`timescale 1ns/10ps

module fetch_unit import if_pkg::*; #(
  parameter int FIFO_DEPTH = IF_FIFO_DEPTH  // prefetch words
) (
  input  logic         clk,
  input  logic         rst_n,

  // target selection
  input  addr_t        boot_addr_i,
  input  addr_t        jump_target_id_i,
  input  addr_t        jump_target_ex_i,
  input  addr_t        mepc_i,
  input  addr_t        depc_i,
  input  addr_t        pc_i,
  input  logic [23:0]  m_trap_base_addr_i,
  input  logic [29:0]  dm_halt_addr_i,
  input  logic [5:0]   m_exc_vec_pc_mux_i,
  input  pc_mux_t      pc_mux_i,
  input  exc_pc_mux_t  exc_pc_mux_i,
  output addr_t        branch_target_o,

  // control
  input  logic         req_i,
  input  logic         pc_set_i,
  input  logic         halt_if_i,
  input  logic         id_ready_i,
  input  logic         clear_instr_valid_i,

  // instruction bus
  output logic         instr_req_o,
  output addr_t        instr_addr_o,
  input  logic         instr_gnt_i,
  input  logic         instr_rvalid_i,
  input  instr_t       instr_rdata_i,

  // to decode
  output logic         instr_valid_id_o,
  output instr_t       instr_rdata_id_o,
  output addr_t        pc_id_o,

  // status
  output logic         if_busy_o,
  output logic         perf_imiss_o
);

  fetch_stream_if fs ();  // buffer to pipe stage

  pc_target_sel u_target (
    .boot_addr_i        (boot_addr_i),
    .jump_target_id_i   (jump_target_id_i),
    .jump_target_ex_i   (jump_target_ex_i),
    .mepc_i             (mepc_i),
    .depc_i             (depc_i),
    .pc_i               (pc_i),
    .m_trap_base_addr_i (m_trap_base_addr_i),
    .dm_halt_addr_i     (dm_halt_addr_i),
    .m_exc_vec_pc_mux_i (m_exc_vec_pc_mux_i),
    .pc_mux_i           (pc_mux_i),
    .exc_pc_mux_i       (exc_pc_mux_i),
    .branch_target_o    (branch_target_o)
  );

  prefetch_buffer #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_prefetch (
    .clk            (clk),
    .rst_n          (rst_n),
    .req_i          (req_i),
    .fs             (fs.buf_mp),
    .instr_req_o    (instr_req_o),
    .instr_addr_o   (instr_addr_o),
    .instr_gnt_i    (instr_gnt_i),
    .instr_rvalid_i (instr_rvalid_i),
    .instr_rdata_i  (instr_rdata_i),
    .busy_o         (if_busy_o)
  );

  if_pipe u_if_pipe (
    .clk                 (clk),
    .rst_n               (rst_n),
    .req_i               (req_i),
    .pc_set_i            (pc_set_i),
    .branch_target_i     (branch_target_o),  // same net that leaves the top
    .fs                  (fs.pipe_mp),
    .halt_if_i           (halt_if_i),
    .id_ready_i          (id_ready_i),
    .clear_instr_valid_i (clear_instr_valid_i),
    .instr_valid_id_o    (instr_valid_id_o),
    .instr_rdata_id_o    (instr_rdata_id_o),
    .pc_id_o             (pc_id_o),
    .perf_imiss_o        (perf_imiss_o)
  );

endmodule

// File: sim/imem_model.sv
// testbench instruction memory, answers the fetch bus with random grant and in-order response delays
`timescale 1ns/10ps

module imem_model #(
  parameter logic [31:0] DATA_XOR = 32'h5a3c_96e1  // word = address ^ pattern
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        req_i,
  input  logic [31:0] addr_i,
  output logic        gnt_o,
  output logic        rvalid_o,
  output logic [31:0] rdata_o,
  output int          outstanding_o  // granted, response not yet taken
);

  logic [31:0] addr_q [$];  // granted addresses, oldest first
  int          due_q  [$];  // cycle in which each response goes out
  int          cyc;         // posedge count since reset
  int          gnt_wait;    // cycles left before the next grant
  int          last_due;

  // bus sampled at the rising edge, everything settled by then
  always @(posedge clk or negedge rst_n) begin
    int due;
    if (!rst_n) begin
      cyc           = 0;
      gnt_wait      = 0;
      last_due      = 0;
      outstanding_o = 0;
      addr_q.delete();
      due_q.delete();
    end else begin
      cyc = cyc + 1;
      if (rvalid_o) outstanding_o = outstanding_o - 1;  // response consumed
      if (req_i && gnt_o) begin
        due = cyc + $urandom_range(4, 1) - 1;           // 1 to 4 cycles after grant
        if (due <= last_due) due = last_due + 1;        // keep responses in order
        addr_q.push_back(addr_i);
        due_q.push_back(due);
        last_due      = due;
        outstanding_o = outstanding_o + 1;
        gnt_wait      = $urandom_range(3, 0);
      end else if (req_i && gnt_wait > 0) begin
        gnt_wait = gnt_wait - 1;
      end
    end
  end

  // outputs change on the falling edge only
  always @(negedge clk or negedge rst_n) begin
    if (!rst_n) begin
      gnt_o    = 1'b0;
      rvalid_o = 1'b0;
      rdata_o  = '0;
    end else begin
      gnt_o = (gnt_wait == 0);
      if (due_q.size() > 0 && due_q[0] <= cyc) begin
        rvalid_o = 1'b1;
        rdata_o  = addr_q.pop_front() ^ DATA_XOR;
        void'(due_q.pop_front());
      end else begin
        rvalid_o = 1'b0;
        rdata_o  = '0;
      end
    end
  end

endmodule

// File: sim/tb_fetch_unit.sv
// fetch unit testbench, random redirects and stalls checked against a PC and IF/ID model
`timescale 1ns/10ps

module tb_fetch_unit import if_pkg::*; ();

  localparam int          FIFO_DEPTH = IF_FIFO_DEPTH;
  localparam logic [31:0] DATA_XOR   = 32'h5a3c_96e1;
  localparam int          NUM_INSTR  = 400;  // instructions to see in decode
  localparam int          MAX_WAIT   = 200;  // cycles per instruction at most

  logic clk;
  logic rst_n;
  addr_t boot_addr, jump_id, jump_ex, mepc, depc, pc_fencei, branch_target;
  logic [23:0] trap_base;
  logic [29:0] halt_addr;
  logic [5:0]  vec_id;
  pc_mux_t     pc_mux;
  exc_pc_mux_t exc_mux;
  logic req, pc_set, halt_if, id_ready, clear_valid;
  logic instr_req, instr_gnt, instr_rvalid;
  addr_t instr_addr;
  instr_t instr_rdata, instr_rdata_id;
  logic instr_valid_id, if_busy, perf_imiss;
  addr_t pc_id;
  int outstanding;

  // reference model state
  addr_t  exp_pc;          // pc of the next word that decode should see
  logic   m_valid;         // expected IF/ID contents
  addr_t  m_pc;
  instr_t m_rdata;
  bit     m_defined;       // IF/ID loaded at least once
  bit     req_on;
  bit     req_seen;
  bit     got;

  fetch_unit #(.FIFO_DEPTH(FIFO_DEPTH)) u_dut (
    .clk(clk), .rst_n(rst_n),
    .boot_addr_i(boot_addr), .jump_target_id_i(jump_id), .jump_target_ex_i(jump_ex),
    .mepc_i(mepc), .depc_i(depc), .pc_i(pc_fencei),
    .m_trap_base_addr_i(trap_base), .dm_halt_addr_i(halt_addr),
    .m_exc_vec_pc_mux_i(vec_id), .pc_mux_i(pc_mux), .exc_pc_mux_i(exc_mux),
    .branch_target_o(branch_target),
    .req_i(req), .pc_set_i(pc_set), .halt_if_i(halt_if), .id_ready_i(id_ready),
    .clear_instr_valid_i(clear_valid),
    .instr_req_o(instr_req), .instr_addr_o(instr_addr), .instr_gnt_i(instr_gnt),
    .instr_rvalid_i(instr_rvalid), .instr_rdata_i(instr_rdata),
    .instr_valid_id_o(instr_valid_id), .instr_rdata_id_o(instr_rdata_id), .pc_id_o(pc_id),
    .if_busy_o(if_busy), .perf_imiss_o(perf_imiss)
  );

  imem_model #(.DATA_XOR(DATA_XOR)) u_imem (
    .clk(clk), .rst_n(rst_n), .req_i(instr_req), .addr_i(instr_addr),
    .gnt_o(instr_gnt), .rvalid_o(instr_rvalid), .rdata_o(instr_rdata),
    .outstanding_o(outstanding)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;  // 20 ns period

  //////////////////////////////////////////////////////////////////////////
  // model and checks
  //////////////////////////////////////////////////////////////////////////

  // next fetch address as the selection rules define it
  function automatic addr_t expected_target();
    addr_t trap;
    case (exc_mux)
      EXC_PC_IRQ: trap = {trap_base, 8'h00} + (32'(vec_id) << 2);  // vectored
      EXC_PC_DBD: trap = 32'(halt_addr) << 2;
      default:    trap = {trap_base, 8'h00};
    endcase
    case (pc_mux)
      PC_JUMP:      return jump_id;
      PC_BRANCH:    return jump_ex;
      PC_EXCEPTION: return trap;
      PC_MRET:      return mepc;
      PC_DRET:      return depc;
      PC_FENCEI:    return pc_fencei + 32'd4;
      default:      return boot_addr;
    endcase
  endfunction

  task automatic check_equal(input logic [31:0] expected, input logic [31:0] actual,
                             input string what);
    if (expected !== actual) begin
      $display("CHECK FAILED at %0t ns: %s expected %h got %h", $time, what, expected,
               actual);
      $display("TB FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  // fresh word aligned targets and select codes every cycle
  task automatic pick_targets();
    pc_mux_t     codes [7];
    exc_pc_mux_t kinds [3];
    codes = '{PC_BOOT, PC_JUMP, PC_BRANCH, PC_EXCEPTION, PC_MRET, PC_DRET, PC_FENCEI};
    kinds = '{EXC_PC_EXCEPTION, EXC_PC_IRQ, EXC_PC_DBD};
    jump_id   = $urandom() & 32'hffff_fffc;
    jump_ex   = $urandom() & 32'hffff_fffc;
    mepc      = $urandom() & 32'hffff_fffc;
    depc      = $urandom() & 32'hffff_fffc;
    pc_fencei = $urandom() & 32'hffff_fffc;
    trap_base = 24'($urandom());
    halt_addr = 30'($urandom());
    vec_id    = 6'($urandom());
    pc_mux    = codes[$urandom_range(6, 0)];
    exc_mux   = kinds[$urandom_range(2, 0)];
  endtask

  // one clock: check the last edge, drive new inputs, predict the next edge
  task automatic drive_cycle(output bit loaded);
    bit load;
    @(negedge clk);
    check_equal(m_valid, instr_valid_id, "instr_valid_id_o");
    if (m_defined) begin
      check_equal(m_pc, pc_id, "pc_id_o");
      check_equal(m_rdata, instr_rdata_id, "instr_rdata_id_o");
    end
    check_equal(1, outstanding <= FIFO_DEPTH, "outstanding requests within fifo depth");
    if (outstanding != 0) begin
      check_equal(1, if_busy, "if_busy_o with requests in flight");
    end
    if (!req_seen) begin
      check_equal(0, instr_req, "instr_req_o before req_i");
      check_equal(0, if_busy, "if_busy_o before req_i");
    end
    pick_targets();
    req         = req_on;
    pc_set      = req_seen && ($urandom_range(19, 0) == 0);
    id_ready    = ($urandom_range(3, 0) != 0);
    halt_if     = ($urandom_range(9, 0) == 0);
    clear_valid = ($urandom_range(15, 0) == 0);
    if (req_on && !req_seen) pc_mux = PC_BOOT;  // first fetch starts at boot
    #1;
    check_equal(expected_target(), branch_target, "branch_target_o");
    // a redirect leaves decode without a word this cycle
    if (pc_set || (req && !req_seen)) begin
      check_equal(1, perf_imiss, "perf_imiss_o on redirect");
    end
    // imiss low means a buffered word is at the head
    load = !perf_imiss && id_ready && !halt_if && !pc_set;
    if (load) begin
      m_valid   = 1'b1;
      m_pc      = exp_pc;
      m_rdata   = exp_pc ^ DATA_XOR;
      m_defined = 1'b1;
      exp_pc    = exp_pc + 32'd4;
    end else if (clear_valid) begin
      m_valid = 1'b0;
    end
    if (pc_set || (req && !req_seen)) begin
      exp_pc   = expected_target();  // redirect, older words are stale
      req_seen = 1'b1;
    end
    loaded = load;
  endtask

  task automatic wait_for_instr();
    int  n;
    bit  hit;
    n   = 0;
    hit = 1'b0;
    while (!hit && n < MAX_WAIT) begin
      drive_cycle(hit);
      n++;
    end
    if (!hit) begin
      $display("no instruction reached decode within %0d cycles", MAX_WAIT);
      $display("TB FAILED");
      $fatal(1, "fetch timeout");
    end
  endtask

  //////////////////////////////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(46773));
    rst_n       = 1'b0;
    boot_addr   = $urandom() & 32'hffff_fffc;  // fixed for the run
    pick_targets();
    req         = 1'b0;
    pc_set      = 1'b0;
    halt_if     = 1'b0;
    id_ready    = 1'b1;
    clear_valid = 1'b0;
    exp_pc      = '0;
    m_valid     = 1'b0;
    m_defined   = 1'b0;
    req_on      = 1'b0;
    req_seen    = 1'b0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    repeat (6) drive_cycle(got);  // idle, bus must stay quiet
    req_on = 1'b1;
    repeat (NUM_INSTR) wait_for_instr();
    drive_cycle(got);             // checks the last load
    $display("TB PASSED");
    $finish;
  end

endmodule

// File: fetch_unit.f
hw/if_pkg.sv
hw/fetch_stream_if.sv
hw/pc_target_sel.sv
hw/prefetch_buffer.sv
hw/if_pipe.sv
hw/fetch_unit.sv
sim/imem_model.sv
sim/tb_fetch_unit.sv
